// File: flist.f
+incdir+.
fft_pkg.sv
fft_butterfly.sv
fft_frame_input.sv
fft_stage.sv
fft_top.sv
tb_clock.sv
tb_fft.sv

// File: tb_fft.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_cfg.svh"

module tb_fft
  import fft_pkg::*;
();

  // all tests take a few hundred cycles
  localparam int max_cycles = 2000;

  logic   clk;
  logic   reset;
  logic   in_valid;
  logic   in_ready;
  frame_t in_frame;
  logic   out_valid;
  logic   out_ready;
  frame_t out_frame;

  frame_t      exp_q[$];
  logic [31:0] lfsr_state = 32'h8c09;
  int          cycle_count = 0;
  int          last_accept = 0;

  // W8^k with 1.0 as 1024
  int tw_re [0:3] = '{1024, 724, 0, -724};
  int tw_im [0:3] = '{0, -724, -1024, -724};

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  fft_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_frame  (in_frame),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_frame (out_frame)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] want);
    if (got !== want)
    begin
      report_failure($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                               $time, name, got, want));
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic next_rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb)
      lfsr_state = lfsr_state ^ 32'h80200003;
    return lsb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | next_rand_bit();
    return v;
  endfunction

  // sign bit plus 10 magnitude bits
  function automatic sample_t rand_sample();
    int mag;
    mag = rand_bits(10);
    if (rand_bits(1) != 0)
      mag = -mag;
    return sample_t'(mag);
  endfunction

  function automatic frame_t random_frame();
    frame_t f;
    for (int k = 0; k < `FFT_POINTS; k++)
    begin
      f[k].re = rand_sample();
      f[k].im = rand_sample();
    end
    return f;
  endfunction

  function automatic frame_t fft_model(input frame_t x);
    sample_t re [`FFT_POINTS];
    sample_t im [`FFT_POINTS];
    frame_t  y;
    int      r;
    int      span;
    int      lo;
    int      hi;
    int      k;
    longint  pr;
    longint  pi;
    sample_t tr;
    sample_t ti;
    for (int p = 0; p < `FFT_POINTS; p++)
    begin
      r = 0;
      for (int b = 0; b < `FFT_STAGES; b++)
        if (p & (1 << b))
          r |= 1 << (`FFT_STAGES - 1 - b);
      re[p] = x[r].re;
      im[p] = x[r].im;
    end
    for (int s = 0; s < `FFT_STAGES; s++)
    begin
      span = 1 << s;
      for (int g = 0; g < `FFT_POINTS / 2; g++)
      begin
        lo = (g / span) * 2 * span + g % span;
        hi = lo + span;
        k  = (g % span) * (`FFT_POINTS / (2 * span));
        pr = longint'(re[hi]) * tw_re[k] - longint'(im[hi]) * tw_im[k];
        pi = longint'(re[hi]) * tw_im[k] + longint'(im[hi]) * tw_re[k];
        // floor shift back to sample scale
        tr = sample_t'(pr >>> `FFT_TW_FRAC);
        ti = sample_t'(pi >>> `FFT_TW_FRAC);
        re[hi] = re[lo] - tr;
        im[hi] = im[lo] - ti;
        re[lo] = re[lo] + tr;
        im[lo] = im[lo] + ti;
      end
    end
    for (int p = 0; p < `FFT_POINTS; p++)
    begin
      y[p].re = re[p];
      y[p].im = im[p];
    end
    return y;
  endfunction

  task automatic compare_frame(input frame_t got, input frame_t want);
    for (int k = 0; k < `FFT_POINTS; k++)
    begin
      check_value($sformatf("out_frame[%0d].re", k), got[k].re, want[k].re);
      check_value($sformatf("out_frame[%0d].im", k), got[k].im, want[k].im);
    end
  endtask

  // returns at the falling edge before the transfer edge
  task automatic send_frame(input frame_t f, input frame_t want);
    @(posedge clk);
    in_valid <= 1'b1;
    in_frame <= f;
    @(negedge clk);
    while (!in_ready)
      @(negedge clk);
    exp_q.push_back(want);
    last_accept = cycle_count;
  endtask

  task automatic idle_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic set_out_ready(input logic v);
    @(posedge clk);
    out_ready <= v;
  endtask

  task automatic wait_for_drain();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  // scoreboard sampling outputs mid-cycle
  always @(negedge clk)
  begin
    if (!reset && out_valid && out_ready)
    begin
      if (exp_q.size() == 0)
        report_failure("output frame arrived with no input frame outstanding");
      else
      begin
        compare_frame(out_frame, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
      report_failure($sformatf("timeout after %0d cycles, tests did not finish", cycle_count));
  end

  task automatic test_reset_state();
    check_value("out_valid", out_valid, 0);
    check_value("in_ready", in_ready, 1);
  endtask

  task automatic test_impulse_dc();
    frame_t f;
    frame_t want;
    f = '0;
    f[0].re = 500;
    want = '0;
    for (int k = 0; k < `FFT_POINTS; k++)
      want[k].re = 500;
    send_frame(f, want);
    f = '0;
    want = '0;
    for (int k = 0; k < `FFT_POINTS; k++)
      f[k].re = 100;
    want[0].re = 800;
    send_frame(f, want);
    idle_input();
    wait_for_drain();
  endtask

  task automatic test_latency();
    frame_t f;
    int     lat;
    f = random_frame();
    send_frame(f, fft_model(f));
    idle_input();
    lat = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end
    while (!out_valid && lat < 10);
    check_value("out_valid latency", lat, 4);
    wait_for_drain();
  endtask

  task automatic test_streaming();
    frame_t f;
    int     first;
    first = 0;
    for (int i = 0; i < 8; i++)
    begin
      f = random_frame();
      send_frame(f, fft_model(f));
      if (i == 0)
        first = last_accept;
    end
    idle_input();
    check_value("cycles from first to last accept", last_accept - first, 7);
    wait_for_drain();
  endtask

  task automatic test_back_pressure();
    frame_t f;
    logic   stop;
    set_out_ready(1'b0);
    for (int i = 0; i < 4; i++)
    begin
      f = random_frame();
      send_frame(f, fft_model(f));
    end
    idle_input();
    @(negedge clk);
    check_value("in_ready with four frames held", in_ready, 0);
    stop = 1'b0;
    fork
      begin
        for (int i = 0; i < 12; i++)
        begin
          f = random_frame();
          send_frame(f, fft_model(f));
        end
        idle_input();
        wait_for_drain();
        stop = 1'b1;
      end
      begin
        while (!stop)
        begin
          @(posedge clk);
          out_ready <= next_rand_bit();
        end
      end
    join
    set_out_ready(1'b1);
  endtask

  initial
  begin
    in_valid  <= 1'b0;
    in_frame  <= '0;
    out_ready <= 1'b0;
    @(negedge clk);
    while (reset)
      @(negedge clk);
    test_reset_state();
    set_out_ready(1'b1);
    test_impulse_dc();
    test_latency();
    test_streaming();
    test_back_pressure();
    // idle cycles so a stray or repeated frame reaches the scoreboard
    repeat (6) @(negedge clk);
    check_value("out_valid after drain", out_valid, 0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
  output logic clk,
  output logic reset
);

  localparam int reset_cycles = 16;

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: fft_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_top
  import fft_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  output logic   in_ready,
  input  frame_t in_frame,
  output logic   out_valid,
  input  logic   out_ready,
  output frame_t out_frame
);

  // input register to stage 0
  logic   rev_valid;
  logic   rev_ready;
  frame_t rev_frame;

  // stage 0 to stage 1
  logic   s0_valid;
  logic   s0_ready;
  frame_t s0_frame;

  // stage 1 to stage 2
  logic   s1_valid;
  logic   s1_ready;
  frame_t s1_frame;

  fft_frame_input u_input (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_frame  (in_frame),
    .out_valid (rev_valid),
    .out_ready (rev_ready),
    .out_frame (rev_frame)
  );

  fft_stage #(
    .STAGE (0)
  ) u_stage0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (rev_valid),
    .in_ready  (rev_ready),
    .in_frame  (rev_frame),
    .out_valid (s0_valid),
    .out_ready (s0_ready),
    .out_frame (s0_frame)
  );

  fft_stage #(
    .STAGE (1)
  ) u_stage1 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (s0_valid),
    .in_ready  (s0_ready),
    .in_frame  (s0_frame),
    .out_valid (s1_valid),
    .out_ready (s1_ready),
    .out_frame (s1_frame)
  );

  // last stage leaves X[k] at natural position k
  fft_stage #(
    .STAGE (2)
  ) u_stage2 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (s1_valid),
    .in_ready  (s1_ready),
    .in_frame  (s1_frame),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_frame (out_frame)
  );

endmodule

`default_nettype wire

// File: fft_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_cfg.svh"

module fft_stage
  import fft_pkg::*;
#(
  parameter int STAGE = 0
)
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  output logic   in_ready,
  input  frame_t in_frame,
  output logic   out_valid,
  input  logic   out_ready,
  output frame_t out_frame
);

  // distance between the two points of a butterfly
  localparam int span = 1 << STAGE;

  // twiddle index step inside a group
  localparam int tw_step = `FFT_POINTS / (2 * span);

  if (STAGE < 0 || STAGE >= `FFT_STAGES)
  begin : gen_bad_stage
    $error("fft_stage: STAGE %0d out of range", STAGE);
  end

  wire frame_t result;

  frame_t frame_q;
  logic   full_q;
  logic   accept;

  // butterfly g works on positions lo and lo + span of its group
  for (genvar g = 0; g < `FFT_POINTS / 2; g++)
  begin : gen_bfly
    localparam int grp = g / span;
    localparam int j   = g % span;
    localparam int lo  = grp * 2 * span + j;
    localparam int hi  = lo + span;
    localparam twiddle_t w = twiddle(j * tw_step);

    fft_butterfly u_bfly (
      .a      (in_frame[lo]),
      .b      (in_frame[hi]),
      .w      (w),
      .top    (result[lo]),
      .bottom (result[hi])
    );
  end

  assign in_ready = !full_q || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full_q <= 1'b0;
    end
    else if (in_ready)
    begin
      full_q <= in_valid;
    end
  end

  // results go back to the positions they came from
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      frame_q <= result;
    end
  end

  assign out_valid = full_q;
  assign out_frame = frame_q;

  // a frame offered downstream is not withdrawn or changed while stalled
  a_out_hold: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_frame)
  );

endmodule

`default_nettype wire

// File: fft_frame_input.sv
`timescale 1ns/1ps
`default_nettype none

module fft_frame_input
  import fft_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  output logic   in_ready,
  input  frame_t in_frame,
  output logic   out_valid,
  input  logic   out_ready,
  output frame_t out_frame
);

  frame_t frame_q;
  frame_t reordered;
  logic   full_q;
  logic   accept;

  function automatic logic [fft_stages-1:0] bitrev(input logic [fft_stages-1:0] p);
    logic [fft_stages-1:0] r;
    for (int i = 0; i < fft_stages; i++)
    begin
      r[i] = p[fft_stages-1-i];
    end
    return r;
  endfunction

  // position p takes sample bitrev(p) so stage 0 works in place
  always_comb
  begin
    for (int p = 0; p < fft_points; p++)
    begin
      reordered[p] = in_frame[bitrev(fft_stages'(p))];
    end
  end

  // free when empty or when the held frame leaves this cycle
  assign in_ready = !full_q || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full_q <= 1'b0;
    end
    else if (in_ready)
    begin
      full_q <= in_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      frame_q <= reordered;
    end
  end

  assign out_valid = full_q;
  assign out_frame = frame_q;

  // a stalled source keeps its frame until it is taken
  a_in_hold: assert property (
    @(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_frame)
  );

endmodule

`default_nettype wire

// File: fft_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly
  import fft_pkg::*;
(
  input  cplx_t    a,
  input  cplx_t    b,
  input  twiddle_t w,
  output cplx_t    top,
  output cplx_t    bottom
);

  // two products plus one bit for the sum
  localparam int prod_width = $bits(sample_t) + $bits(tw_coef_t) + 1;

  logic signed [prod_width-1:0] prod_re;
  logic signed [prod_width-1:0] prod_im;
  sample_t                      t_re;
  sample_t                      t_im;

  // complex multiply b * w at full precision
  always_comb
  begin
    prod_re = b.re * w.re - b.im * w.im;
    prod_im = b.re * w.im + b.im * w.re;
  end

  // back to sample scale with floor rounding
  always_comb
  begin
    t_re = sample_t'(prod_re >>> tw_frac);
    t_im = sample_t'(prod_im >>> tw_frac);
  end

  always_comb
  begin
    top.re    = a.re + t_re;
    top.im    = a.im + t_im;
    bottom.re = a.re - t_re;
    bottom.im = a.im - t_im;
  end

endmodule

`default_nettype wire

// File: fft_pkg.sv
`default_nettype none

`include "fft_cfg.svh"

package fft_pkg;

  localparam int fft_points = `FFT_POINTS;
  localparam int fft_stages = `FFT_STAGES;
  localparam int tw_frac = `FFT_TW_FRAC;

  typedef logic signed [`FFT_SAMPLE_WIDTH-1:0] sample_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // index 0 sits at the low end
  typedef cplx_t [`FFT_POINTS-1:0] frame_t;

  typedef logic signed [11:0] tw_coef_t;

  typedef struct packed {
    tw_coef_t re;
    tw_coef_t im;
  } twiddle_t;

  // W8^k for k in 0..3
  function automatic twiddle_t twiddle(input int k);
    twiddle_t w;
    case (k)
      1:
      begin
        w.re = 12'sd724;
        w.im = -12'sd724;
      end
      2:
      begin
        w.re = 12'sd0;
        w.im = -12'sd1024;
      end
      3:
      begin
        w.re = -12'sd724;
        w.im = -12'sd724;
      end
      default:
      begin
        w.re = 12'sd1024;
        w.im = 12'sd0;
      end
    endcase
    return w;
  endfunction

endpackage

`default_nettype wire

// File: fft_cfg.svh
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// points per frame
`define FFT_POINTS 8

// log2 of the point count
`define FFT_STAGES 3

// signed width of one real or imaginary part
// inputs within +-1000 can grow 8x over three stages
`define FFT_SAMPLE_WIDTH 18

// twiddles in Q-format where 1.0 is 1024
`define FFT_TW_FRAC 10

`endif
